// ==== des_settings.svh ====
`ifndef DES_SETTINGS_SVH
`define DES_SETTINGS_SVH

// Datapath widths
`define DES_BLOCK_W     64  // Message and result
`define DES_HALF_W      32  // L and R halves
`define DES_KEY_W       64  // Key including parity bits
`define DES_SUBKEY_W    48  // One round key
`define DES_CD_W        28  // C or D register in the key schedule

// Round structure
`define DES_ROUNDS      16
`define DES_UNROLL      4   // Rounds per pass through the core

// Sixteen subkeys, round 1 in the top slot
`define DES_RKEY_BUS_W  768

`endif

// ==== des_pkg.sv ====
`include "des_settings.svh"

package des_pkg;

	typedef enum logic [1:0] {ENC_IDLE, ENC_ROUNDS, ENC_DONE} enc_state_t;
	typedef enum logic [1:0] {KS_IDLE, KS_RUN, KS_READY} ks_state_t;

	// Tables use the standard numbering, bit 1 is the MSB
	localparam int IP_TAB [64] = '{
		58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

	localparam int FP_TAB [64] = '{
		40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25};

	localparam int E_TAB [48] = '{
		32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9,
		8, 9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};

	localparam int P_TAB [32] = '{
		16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
		2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};

	localparam int PC1_TAB [56] = '{
		57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
		10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};

	localparam int PC2_TAB [48] = '{
		14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
		23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

	// One row per line, index is row * 16 + column
	localparam logic [3:0] SBOX [8][64] = '{
		'{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
		  0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
		  4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
		  15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
		'{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
		  3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
		  0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
		  13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
		'{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
		  13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
		  13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
		  1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
		'{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
		  13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
		  10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
		  3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
		'{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
		  14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
		  4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
		  11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
		'{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
		  10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
		  9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
		  4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
		'{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
		  13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
		  1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
		  6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
		'{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
		  1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
		  7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
		  2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}};

	function automatic logic [`DES_BLOCK_W-1:0] initial_perm(input logic [`DES_BLOCK_W-1:0] d);
		logic [`DES_BLOCK_W-1:0] q;
		for (int i = 0; i < `DES_BLOCK_W; i++) begin
			q[`DES_BLOCK_W-1-i] = d[`DES_BLOCK_W-IP_TAB[i]];
		end
		return q;
	endfunction

	function automatic logic [`DES_BLOCK_W-1:0] final_perm(input logic [`DES_BLOCK_W-1:0] d);
		logic [`DES_BLOCK_W-1:0] q;
		for (int i = 0; i < `DES_BLOCK_W; i++) begin
			q[`DES_BLOCK_W-1-i] = d[`DES_BLOCK_W-FP_TAB[i]];
		end
		return q;
	endfunction

	function automatic logic [`DES_SUBKEY_W-1:0] expand(input logic [`DES_HALF_W-1:0] r);
		logic [`DES_SUBKEY_W-1:0] q;
		for (int i = 0; i < `DES_SUBKEY_W; i++) begin
			q[`DES_SUBKEY_W-1-i] = r[`DES_HALF_W-E_TAB[i]];
		end
		return q;
	endfunction

	function automatic logic [`DES_HALF_W-1:0] sbox_subst(input logic [`DES_SUBKEY_W-1:0] x);
		logic [`DES_HALF_W-1:0] y;
		logic [5:0] b;
		for (int i = 0; i < 8; i++) begin
			b = x[`DES_SUBKEY_W-1-6*i -: 6];
			y[`DES_HALF_W-1-4*i -: 4] = SBOX[i][{b[5], b[0], b[4:1]}]; // Outer bits pick the row
		end
		return y;
	endfunction

	function automatic logic [`DES_HALF_W-1:0] p_perm(input logic [`DES_HALF_W-1:0] x);
		logic [`DES_HALF_W-1:0] q;
		for (int i = 0; i < `DES_HALF_W; i++) begin
			q[`DES_HALF_W-1-i] = x[`DES_HALF_W-P_TAB[i]];
		end
		return q;
	endfunction

	// Parity bits are dropped here
	function automatic logic [2*`DES_CD_W-1:0] pc1(input logic [`DES_KEY_W-1:0] k);
		logic [2*`DES_CD_W-1:0] q;
		for (int i = 0; i < 2 * `DES_CD_W; i++) begin
			q[2*`DES_CD_W-1-i] = k[`DES_KEY_W-PC1_TAB[i]];
		end
		return q;
	endfunction

	function automatic logic [`DES_SUBKEY_W-1:0] pc2(input logic [2*`DES_CD_W-1:0] cd);
		logic [`DES_SUBKEY_W-1:0] q;
		for (int i = 0; i < `DES_SUBKEY_W; i++) begin
			q[`DES_SUBKEY_W-1-i] = cd[2*`DES_CD_W-PC2_TAB[i]];
		end
		return q;
	endfunction

	// Round index counts from 0
	function automatic logic [1:0] shift_amount(input logic [3:0] idx);
		return (idx == 4'd0 || idx == 4'd1 || idx == 4'd8 || idx == 4'd15) ? 2'd1 : 2'd2;
	endfunction

endpackage

// ==== des_round.sv ====
`include "des_settings.svh"

module des_round (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic [`DES_HALF_W-1:0]   l_in,
	input  logic [`DES_HALF_W-1:0]   r_in,
	input  logic [`DES_SUBKEY_W-1:0] subkey,
	output logic                     done,
	output logic [`DES_HALF_W-1:0]   l_out,
	output logic [`DES_HALF_W-1:0]   r_out
);

	logic [`DES_SUBKEY_W-1:0] mixed;
	logic [`DES_HALF_W-1:0]   f_out;

	// Feistel function
	assign mixed = des_pkg::expand(r_in) ^ subkey;
	assign f_out = des_pkg::p_perm(des_pkg::sbox_subst(mixed));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= start; // One cycle behind start
		end
	end

	// Halves only move on start
	always_ff @(posedge clk) begin
		if (start) begin
			l_out <= r_in;
			r_out <= l_in ^ f_out;
		end
	end

endmodule

// ==== des_key_schedule.sv ====
`include "des_settings.svh"

module des_key_schedule (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       key_load,
	input  logic [`DES_KEY_W-1:0]      key,
	output logic [`DES_RKEY_BUS_W-1:0] round_keys,
	output logic                       keys_ready
);

	des_pkg::ks_state_t state;
	logic [3:0]            rnd;            // Slot being written
	logic [`DES_CD_W-1:0]  c_reg, d_reg;
	logic [`DES_CD_W-1:0]  c_nxt, d_nxt;
	logic [1:0]            amt;

	// Left rotate by one or two
	function automatic logic [`DES_CD_W-1:0] rotl(input logic [`DES_CD_W-1:0] x,
		input logic [1:0] n);
		if (n == 2'd2) begin
			return {x[`DES_CD_W-3:0], x[`DES_CD_W-1:`DES_CD_W-2]};
		end
		return {x[`DES_CD_W-2:0], x[`DES_CD_W-1]};
	endfunction

	assign amt        = des_pkg::shift_amount(rnd);
	assign c_nxt      = rotl(c_reg, amt);
	assign d_nxt      = rotl(d_reg, amt);
	assign keys_ready = (state == des_pkg::KS_READY);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= des_pkg::KS_IDLE;
			rnd   <= '0;
		end else if (key_load) begin // Restarts from any state
			state <= des_pkg::KS_RUN;
			rnd   <= '0;
		end else if (state == des_pkg::KS_RUN) begin
			rnd <= rnd + 4'd1;
			if (rnd == 4'(`DES_ROUNDS - 1)) begin
				state <= des_pkg::KS_READY;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (key_load) begin
			{c_reg, d_reg} <= des_pkg::pc1(key);
		end else if (state == des_pkg::KS_RUN) begin
			c_reg <= c_nxt;
			d_reg <= d_nxt;
			// Round 1 lands in the top slot
			round_keys[`DES_RKEY_BUS_W-1 - rnd*`DES_SUBKEY_W -: `DES_SUBKEY_W]
				<= des_pkg::pc2({c_nxt, d_nxt});
		end
	end

endmodule

// ==== des_encrypt_unroll4.sv ====
`include "des_settings.svh"

module des_encrypt_unroll4 (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  logic [`DES_BLOCK_W-1:0]    message,
	input  logic [`DES_RKEY_BUS_W-1:0] round_keys,
	input  logic                       keys_ready,
	output logic                       busy,
	output logic                       done,
	output logic [`DES_BLOCK_W-1:0]    result
);

	des_pkg::enc_state_t state;
	logic [1:0]                 pass_cnt;
	logic                       kick;       // Stage start, one cycle after a load
	logic                       accept;
	logic                       pass_done;
	logic                       last_pass;
	logic [`DES_BLOCK_W-1:0]    msg_reg;
	logic [`DES_RKEY_BUS_W-1:0] key_sh;

	// Stage chain, index 0 is the pass input
	logic [`DES_UNROLL:0]   stg_go;
	logic [`DES_HALF_W-1:0] stg_l [`DES_UNROLL+1];
	logic [`DES_HALF_W-1:0] stg_r [`DES_UNROLL+1];

	assign accept    = (state == des_pkg::ENC_IDLE) && start && keys_ready;
	assign pass_done = stg_go[`DES_UNROLL];
	assign last_pass = (pass_cnt == 2'(`DES_ROUNDS / `DES_UNROLL - 1));
	assign busy      = (state != des_pkg::ENC_IDLE);
	assign done      = (state == des_pkg::ENC_DONE);

	assign stg_go[0] = kick;
	assign stg_l[0]  = msg_reg[`DES_BLOCK_W-1:`DES_HALF_W];
	assign stg_r[0]  = msg_reg[`DES_HALF_W-1:0];

	for (genvar g = 0; g < `DES_UNROLL; g++) begin : g_stage
		des_round u_round (
			.clk    (clk),
			.rst_n  (rst_n),
			.start  (stg_go[g]),
			.l_in   (stg_l[g]),
			.r_in   (stg_r[g]),
			.subkey (key_sh[`DES_RKEY_BUS_W-1 - g*`DES_SUBKEY_W -: `DES_SUBKEY_W]),
			.done   (stg_go[g+1]),
			.l_out  (stg_l[g+1]),
			.r_out  (stg_r[g+1])
		);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= des_pkg::ENC_IDLE;
			pass_cnt <= '0;
			kick     <= 1'b0;
		end else begin
			kick <= 1'b0;
			case (state)
				des_pkg::ENC_IDLE: begin
					if (accept) begin
						state    <= des_pkg::ENC_ROUNDS;
						pass_cnt <= '0;
						kick     <= 1'b1;
					end
				end
				des_pkg::ENC_ROUNDS: begin
					if (pass_done) begin
						pass_cnt <= pass_cnt + 2'd1;
						if (last_pass) state <= des_pkg::ENC_DONE;
						else kick <= 1'b1; // Next pass
					end
				end
				default: state <= des_pkg::ENC_IDLE; // ENC_DONE lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			msg_reg <= des_pkg::initial_perm(message);
			key_sh  <= round_keys;
		end else if (pass_done) begin
			msg_reg <= {stg_l[`DES_UNROLL], stg_r[`DES_UNROLL]};
			key_sh  <= key_sh << (`DES_UNROLL * `DES_SUBKEY_W);
		end
	end

	// Halves swapped before the final permutation
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
		end else if (pass_done && last_pass) begin
			result <= des_pkg::final_perm({stg_r[`DES_UNROLL], stg_l[`DES_UNROLL]});
		end
	end

endmodule

// ==== des_top.sv ====
`include "des_settings.svh"

module des_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    key_load,
	input  logic [`DES_KEY_W-1:0]   key,
	input  logic                    start,
	input  logic [`DES_BLOCK_W-1:0] message,
	output logic                    keys_ready,
	output logic                    busy,
	output logic                    done,
	output logic [`DES_BLOCK_W-1:0] result
);

	logic [`DES_RKEY_BUS_W-1:0] round_keys; // All sixteen subkeys

	des_key_schedule u_key_schedule (
		.clk        (clk),
		.rst_n      (rst_n),
		.key_load   (key_load),
		.key        (key),
		.round_keys (round_keys),
		.keys_ready (keys_ready)
	);

	// Core only accepts start once keys are ready
	des_encrypt_unroll4 u_encrypt (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.message    (message),
		.round_keys (round_keys),
		.keys_ready (keys_ready),
		.busy       (busy),
		.done       (done),
		.result     (result)
	);

endmodule

// ==== tb_des_top.sv ====
`include "des_settings.svh"

module tb_des_top;

	localparam int NUM_OPS        = 12;
	localparam int TIMEOUT_CYCLES = 4 * NUM_OPS * 40 + 80; // About 40 cycles per operation

	// Known-answer vectors
	localparam logic [`DES_KEY_W-1:0] KAT_KEY [3] = '{
		64'h1334_5779_9BBC_DFF1, 64'h0E32_9232_EA6D_0D73, 64'h0000_0000_0000_0000};
	localparam logic [`DES_BLOCK_W-1:0] KAT_PT [3] = '{
		64'h0123_4567_89AB_CDEF, 64'h8787_8787_8787_8787, 64'h0000_0000_0000_0000};
	localparam logic [`DES_BLOCK_W-1:0] KAT_CT [3] = '{
		64'h85E8_1354_0F0A_B405, 64'h0000_0000_0000_0000, 64'h8CA6_4DE9_C1B1_23A7};

	logic                    clk;
	logic                    rst_n;
	logic                    key_load;
	logic [`DES_KEY_W-1:0]   key;
	logic                    start;
	logic [`DES_BLOCK_W-1:0] message;
	logic                    keys_ready;
	logic                    busy;
	logic                    done;
	logic [`DES_BLOCK_W-1:0] result;

	logic [31:0]             rand_state;
	logic [`DES_BLOCK_W-1:0] exp_result;  // Ciphertext of the operation in flight
	logic [`DES_BLOCK_W-1:0] hold_exp;    // Last delivered ciphertext
	logic [4:0]              ks_wait;
	logic                    ks_loaded;
	logic [4:0]              enc_left;
	logic                    ready_exp, busy_exp, done_exp;
	int                      reset_errors, timing_errors, data_errors;
	int                      cycles;
	int                      loaded_vec;
	int                      vec;

	des_top UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.key_load   (key_load),
		.key        (key),
		.start      (start),
		.message    (message),
		.keys_ready (keys_ready),
		.busy       (busy),
		.done       (done),
		.result     (result)
	);

	always #20 clk = ~clk;

	// Reference timing, 16 cycles of key schedule and 21 cycles per block
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ks_wait   <= '0;
			ks_loaded <= 1'b0;
			enc_left  <= '0;
			hold_exp  <= '0;
		end else begin
			if (key_load) begin
				ks_loaded <= 1'b1;
				ks_wait   <= 5'd16;
			end else if (ks_wait != 5'd0) begin
				ks_wait <= ks_wait - 5'd1;
			end
			if (enc_left == 5'd0 && start && ready_exp) enc_left <= 5'd21;
			else if (enc_left != 5'd0) enc_left <= enc_left - 5'd1;
			if (done_exp) hold_exp <= exp_result; // Result latched with done
		end
	end

	assign ready_exp = ks_loaded && (ks_wait == 5'd0);
	assign busy_exp  = (enc_left != 5'd0);
	assign done_exp  = (enc_left == 5'd1);

	a_reset_outputs: assert property (@(posedge clk)
		((!rst_n && $past(!rst_n)) || $rose(rst_n)) |->
		(!done && !busy && !keys_ready && result == '0))
		else begin
			reset_errors++;
			$display("CHECK FAILED at %0t: outputs not cleared by reset", $time);
		end

	a_keys_ready: assert property (@(posedge clk) disable iff (!rst_n)
		keys_ready == ready_exp)
		else begin
			timing_errors++;
			$display("CHECK FAILED at %0t: keys_ready is %0b, expected %0b",
				$time, $sampled(keys_ready), $sampled(ready_exp));
		end

	a_busy: assert property (@(posedge clk) disable iff (!rst_n) busy == busy_exp)
		else begin
			timing_errors++;
			$display("CHECK FAILED at %0t: busy is %0b, expected %0b",
				$time, $sampled(busy), $sampled(busy_exp));
		end

	a_done: assert property (@(posedge clk) disable iff (!rst_n) done == done_exp)
		else begin
			timing_errors++;
			$display("CHECK FAILED at %0t: done is %0b, expected %0b",
				$time, $sampled(done), $sampled(done_exp));
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			timing_errors++;
			$display("CHECK FAILED at %0t: done longer than one cycle", $time);
		end

	a_result: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> result == exp_result)
		else begin
			data_errors++;
			$display("CHECK FAILED at %0t: result %h, expected %h",
				$time, $sampled(result), $sampled(exp_result));
		end

	// Only the idle window, the core may update result while busy
	a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!busy_exp |-> result == hold_exp)
		else begin
			data_errors++;
			$display("CHECK FAILED at %0t: result %h changed while idle, held %h",
				$time, $sampled(result), $sampled(hold_exp));
		end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [31:0] rand_word();
		rand_state = lcg_step(rand_state);
		return rand_state;
	endfunction

	function int rand_below(input int n);
		logic [31:0] w;
		w = rand_word();
		return int'(w >> 16) % n; // Upper bits are the better ones
	endfunction

	task automatic tick(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Start pulse that the core must ignore
	task automatic pulse_stray_start();
		start   = 1'b1;
		message = {rand_word(), rand_word()};
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic load_key(input logic [`DES_KEY_W-1:0] k, input bit stray_start);
		key_load = 1'b1;
		key      = k;
		@(negedge clk);
		key_load = 1'b0;
		key      = ~k; // Key is only sampled with the strobe
		if (stray_start) begin
			tick(rand_below(14));
			pulse_stray_start();
		end
		while (!keys_ready) @(negedge clk);
	endtask

	task automatic encrypt_block(input int idx, input bit stray_start);
		tick(rand_below(8));
		while (busy || !keys_ready) @(negedge clk);
		start      = 1'b1;
		message    = KAT_PT[idx];
		exp_result = KAT_CT[idx];
		@(negedge clk);
		start   = 1'b0;
		message = {rand_word(), rand_word()};
		if (stray_start) begin
			tick(rand_below(17));
			pulse_stray_start();
		end
		while (!done) @(negedge clk);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("Error counts: reset %0d, timing %0d, data %0d",
				reset_errors, timing_errors, data_errors);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		key_load      = 1'b0;
		key           = '0;
		start         = 1'b0;
		message       = '0;
		exp_result    = '0;
		rand_state    = 32'he998_ccd7;
		reset_errors  = 0;
		timing_errors = 0;
		data_errors   = 0;
		cycles        = 0;
		loaded_vec    = -1;

		tick(5);
		rst_n = 1'b1;
		tick(2);
		pulse_stray_start(); // No key loaded yet
		tick(2);

		for (int op = 0; op < NUM_OPS; op++) begin
			vec = rand_below(3);
			// Forced reload at op 6 covers a drop of keys_ready while ready
			if (vec != loaded_vec || op == 6) begin
				tick(rand_below(8));
				load_key(KAT_KEY[vec], (op % 2) == 0);
				loaded_vec = vec;
			end
			encrypt_block(vec, (op % 3) == 1);
		end
		tick(4);

		$display("Error counts: reset %0d, timing %0d, data %0d",
			reset_errors, timing_errors, data_errors);
		if (reset_errors + timing_errors + data_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== des_top.f ====
+incdir+.
des_pkg.sv
des_round.sv
des_key_schedule.sv
des_encrypt_unroll4.sv
des_top.sv
tb_des_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DES testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module tb_des_top -f des_top.f \
	-o sim_des > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_des 2>&1 | tee "$SIM_LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
	echo "Simulation exited with an error status"
	exit 1
fi

if grep -q "Test failures found" "$SIM_LOG"; then
	exit 1
fi
exit 0
